/* project.f */
verilog/synctimer_pkg.sv
verilog/cycle_estimator.sv
verilog/phase_error_estimator.sv
verilog/divider_multicycle.sv
verilog/adjust_pulse_gen.sv
verilog/synctimer_adjust.sv
tests/tb_synctimer_adjust.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it; exit status follows the simulation
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_synctimer_adjust \
    -f project.f \
    --Mdir obj_dir \
    -o tb_synctimer_adjust
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_synctimer_adjust
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* tests/tb_synctimer_adjust.sv */
// testbench for synctimer_adjust: clock, reset, stimulus, pulse monitor, check task, directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_synctimer_adjust
    import synctimer_pkg::*;
();

    localparam int N_CLOCKS       = 400;     // clocks between corrections
    localparam int RESET_CYCLES   = 8;
    localparam int SETTLE         = 3;       // corrections before counting
    localparam int MEASURE        = 3;       // counted intervals per rate test
    localparam int STALL_START    = 50;      // step in interval where ready drops
    localparam int STALL_LEN      = 200;
    localparam int BIG_ERROR      = 40;
    localparam int TIMEOUT_CYCLES = 60 * N_CLOCKS + 6000;   // 60 corrections plus margin

    logic  clk;
    logic  reset;
    time_t current_time;
    time_t correct_time;
    logic  correct_override;
    logic  correct_valid;
    logic  adjust_ready;
    logic  adjust_sign;
    logic  adjust_valid;

    int          cycle_count  = 0;
    int          pulse_total  = 0;  // accepted pulses, both signs
    int          pulse_neg    = 0;  // accepted pulses with sign 1
    int          stall_cycles = 0;  // cycles with valid waiting on ready
    logic        prev_stall   = 1'b0;
    logic        prev_sign    = 1'b0;
    logic [31:0] lfsr_state;

    // ----------------------------------------
    // clock, DUT, timeout
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    synctimer_adjust #(
        .LPF_GAIN_CYCLE   (2),
        .LPF_GAIN_PHASE   (2)
    ) i_synctimer_adjust (
        .clk              (clk),
        .reset            (reset),
        .current_time     (current_time),
        .correct_override (correct_override),
        .correct_time     (correct_time),
        .correct_valid    (correct_valid),
        .adjust_sign      (adjust_sign),
        .adjust_valid     (adjust_valid),
        .adjust_ready     (adjust_ready)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    task automatic check_equal(input longint got, input longint expected, input string what);
        if (got !== expected) begin
            $display("ERR %0t ns: %s: got %0d, expected %0d", $time, what, got, expected);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    // ----------------------------------------
    // pulse monitor, sampled mid cycle
    // ----------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (prev_stall) begin   // waiting pulse must hold
                check_equal(adjust_valid, 1, "adjust_valid dropped before accept");
                check_equal(adjust_sign, prev_sign, "adjust_sign changed before accept");
            end
            // every accept cycle is one pulse
            if (adjust_valid && adjust_ready) begin
                pulse_total = pulse_total + 1;
                if (adjust_sign) begin
                    pulse_neg = pulse_neg + 1;
                end
            end
            if (adjust_valid && !adjust_ready) begin
                stall_cycles = stall_cycles + 1;
            end
        end
        prev_stall  = !reset && adjust_valid && !adjust_ready;
        prev_sign   = adjust_sign;
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic step_clock();
        @(posedge clk);
        #1;
        current_time = current_time + time_t'(1);   // local free-running timer
    endtask

    task automatic apply_reset();
        reset            = 1'b1;
        correct_valid    = 1'b0;
        correct_override = 1'b0;
        adjust_ready     = 1'b1;
        repeat (RESET_CYCLES) step_clock();
        reset = 1'b0;
    endtask

    // galois lfsr, one step per bit
    function automatic int draw_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // one correction then N_CLOCKS-1 quiet clocks, pulses counted per sign
    task automatic run_interval(input int err, input logic override, input int stall_len,
                                output int n_pos, output int n_neg);
        int         start_total;
        int         start_neg;
        logic       est_seen;
        phase_est_t expected;
        expected.zero = override || (err == 0);     // override restarts at zero
        expected.sign = !override && (err < 0);
        expected.mag  = override ? '0 : error_mag_t'((err < 0) ? -err : err) << ERROR_Q;
        est_seen      = 1'b0;
        step_clock();
        correct_valid    = 1'b1;
        correct_override = override;
        correct_time     = current_time + time_t'(err);
        start_total      = pulse_total;
        start_neg        = pulse_neg;
        for (int k = 1; k < N_CLOCKS; k++) begin
            step_clock();
            correct_valid    = 1'b0;
            correct_override = 1'b0;
            correct_time     = current_time + time_t'(err);
            adjust_ready     = !(k >= STALL_START && k < STALL_START + stall_len);
            if (i_synctimer_adjust.phase_valid) begin
                est_seen = 1'b1;
                check_equal(longint'(i_synctimer_adjust.phase_est), longint'(expected),
                            $sformatf("phase estimate for error %0d", err));
            end
        end
        if (!est_seen) begin
            $display("no phase estimate came out within one correction interval");
            $display("** FAIL **");
            $fatal(1, "missing phase estimate");
        end
        @(negedge clk);     // last sample of this window
        #1;                 // monitor has counted it
        n_neg = pulse_neg - start_neg;
        n_pos = pulse_total - start_total - n_neg;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_quiet_after_reset();
        int start_total;
        int n_pos;
        int n_neg;
        apply_reset();
        start_total = pulse_total;
        repeat (50) step_clock();
        check_equal(pulse_total - start_total, 0, "pulse after reset");
        run_interval(0, 1'b1, 0, n_pos, n_neg);    // override first
        check_equal(n_pos + n_neg, 0, "pulse after override");
        repeat (4) begin
            run_interval(0, 1'b0, 0, n_pos, n_neg);
            check_equal(n_pos + n_neg, 0, "pulse with zero error");
        end
    endtask

    task automatic test_pulse_rate(input int err);
        int n_pos;
        int n_neg;
        int mag;
        int count;
        int wrong;
        mag = (err < 0) ? -err : err;
        apply_reset();
        repeat (SETTLE) run_interval(err, 1'b0, 0, n_pos, n_neg);
        repeat (MEASURE) begin
            run_interval(err, 1'b0, 0, n_pos, n_neg);
            count = (err < 0) ? n_neg : n_pos;
            wrong = (err < 0) ? n_pos : n_neg;
            check_equal(wrong, 0, $sformatf("pulses of wrong sign for error %0d", err));
            check_equal(count >= mag - 1 && count <= mag + 1, 1,
                        $sformatf("pulse count %0d for error %0d", count, err));
        end
    endtask

    task automatic test_back_pressure();
        int n_pos;
        int n_neg;
        int start_stall;
        apply_reset();
        repeat (SETTLE) run_interval(10, 1'b0, 0, n_pos, n_neg);
        start_stall = stall_cycles;
        run_interval(10, 1'b0, STALL_LEN, n_pos, n_neg);
        check_equal(stall_cycles > start_stall, 1, "no pulse waited under back-pressure");
        check_equal(n_neg, 0, "negative pulse under back-pressure");
        check_equal(n_pos >= 1 && n_pos < 10, 1,
                    $sformatf("pulse count %0d under back-pressure", n_pos));
    endtask

    task automatic test_override_restart();
        int n_pos;
        int n_neg;
        apply_reset();
        repeat (4) run_interval(BIG_ERROR, 1'b0, 0, n_pos, n_neg);
        check_equal(n_pos > 0, 1, "no pulses with large error");
        run_interval(0, 1'b1, 0, n_pos, n_neg);    // running interval ends here
        repeat (3) begin
            run_interval(0, 1'b0, 0, n_pos, n_neg);
            check_equal(n_pos + n_neg, 0, "pulse after override restart");
        end
    endtask

    initial begin
        int draw;
        reset            = 1'b1;
        current_time     = 32'hFFFF_F000;   // wraps during the run
        correct_time     = '0;
        correct_override = 1'b0;
        correct_valid    = 1'b0;
        adjust_ready     = 1'b1;
        lfsr_state       = 32'd89362;

        test_quiet_after_reset();
        test_pulse_rate(11);
        repeat (3) begin
            draw = draw_bits(5);
            test_pulse_rate(-((draw % 18) + 3));   // magnitude 3 to 20
        end
        test_back_pressure();
        test_override_restart();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/synctimer_adjust.sv */
// synctimer_adjust: top level wiring estimators, divider and pulse generator
`timescale 1ns/1ps
`default_nettype none

module synctimer_adjust
    import synctimer_pkg::*;
#(
    parameter int LPF_GAIN_CYCLE = 2,   // cycle count filter gain 1/2^N
    parameter int LPF_GAIN_PHASE = 2    // phase error filter gain 1/2^N
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire time_t  current_time,
    input  wire logic   correct_override,
    input  wire time_t  correct_time,
    input  wire logic   correct_valid,
    output logic        adjust_sign,
    output logic        adjust_valid,
    input  wire logic   adjust_ready
);

    // ----------------------------------------
    // estimators
    // ----------------------------------------
    cycle_fix_t cycle_est;
    logic       cycle_ready;
    phase_est_t phase_est;
    logic       phase_valid;

    cycle_estimator #(
        .LPF_GAIN_CYCLE (LPF_GAIN_CYCLE)
    ) i_cycle_estimator (
        .clk            (clk),
        .reset          (reset),
        .correct_valid  (correct_valid),
        .cycle_est      (cycle_est),
        .cycle_ready    (cycle_ready)
    );

    phase_error_estimator #(
        .LPF_GAIN_PHASE (LPF_GAIN_PHASE)
    ) i_phase_error_estimator (
        .clk              (clk),
        .reset            (reset),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .current_time     (current_time),
        .correct_time     (correct_time),
        .phase_est        (phase_est),
        .phase_valid      (phase_valid)
    );

    // ----------------------------------------
    // interval division
    // ----------------------------------------
    quotient_t div_dividend;    // cycles Q.ERROR_Q, shifted for Q.ADJUST_Q quotient
    logic      div_start;
    logic      div_ready;
    quotient_t div_quotient;
    logic      div_valid;

    assign div_dividend = quotient_t'(cycle_est) << ADJUST_Q;
    assign div_start    = phase_valid & ~phase_est.zero & cycle_ready & div_ready;

    divider_multicycle i_divider_multicycle (
        .clk        (clk),
        .reset      (reset),
        .s_dividend (div_dividend),
        .s_divisor  (phase_est.mag),
        .s_valid    (div_start),
        .s_ready    (div_ready),
        .m_quotient (div_quotient),
        .m_valid    (div_valid)
    );

    // zero estimate goes straight to the pulse generator
    adjust_pulse_gen i_adjust_pulse_gen (
        .clk          (clk),
        .reset        (reset),
        .div_quotient (div_quotient),
        .div_valid    (div_valid),
        .phase_est    (phase_est),
        .phase_valid  (phase_valid),
        .adjust_ready (adjust_ready),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid)
    );

endmodule

`default_nettype wire

/* verilog/adjust_pulse_gen.sv */
// adjust_pulse_gen: interval parameter register, pulse pacer, output handshake
`timescale 1ns/1ps
`default_nettype none

module adjust_pulse_gen
    import synctimer_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire quotient_t  div_quotient,
    input  wire logic       div_valid,
    input  wire phase_est_t phase_est,
    input  wire logic       phase_valid,
    input  wire logic       adjust_ready,
    output logic            adjust_sign,
    output logic            adjust_valid
);

    localparam quotient_t STEP = quotient_t'(1) << ADJUST_Q;   // one clock

    // ----------------------------------------
    // parameter register
    // ----------------------------------------
    adjust_param_t param;       // latest interval
    logic          pending;     // not yet taken by pacer
    logic          fire;        // pacer interval ended
    quotient_t     new_period;
    logic          param_changed;
    logic          zero_update;

    assign new_period    = div_quotient - STEP;
    assign zero_update   = phase_valid & phase_est.zero;    // bypasses divider
    assign param_changed = param.zero
                         || (new_period != param.period)
                         || (phase_est.sign != param.sign);

    always_ff @(posedge clk) begin
        if (reset) begin
            param   <= '{zero: 1'b1, sign: 1'b0, period: '0};
            pending <= 1'b0;
        end else begin
            if (fire) begin
                pending <= 1'b0;                    // taken this clock
            end

            if (zero_update) begin
                param   <= '{zero: 1'b1, sign: 1'b0, period: '0};
                pending <= (pending & ~fire) | ~param.zero;
            end else if (div_valid) begin
                param.zero   <= 1'b0;
                param.sign   <= phase_est.sign;     // estimate held since division start
                param.period <= new_period;
                pending      <= (pending & ~fire) | param_changed;
            end
        end
    end

    // ----------------------------------------
    // pacer
    // ----------------------------------------
    adjust_param_t cur;         // interval in use
    quotient_t     acc;         // accumulated time

    assign fire = (acc >= cur.period);  // zero state fires every clock, no pulse

    always_ff @(posedge clk) begin
        if (reset) begin
            cur <= '{zero: 1'b1, sign: 1'b0, period: '0};
            acc <= '0;
        end else begin
            acc <= acc + STEP;
            if (fire) begin
                if (pending) begin
                    cur <= param;   // switch only at interval end
                    acc <= '0;
                end else begin
                    acc <= acc - cur.period;    // keep fraction
                end
            end
        end
    end

    // ----------------------------------------
    // output handshake
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_sign  <= 1'b0;
            adjust_valid <= 1'b0;
        end else begin
            if (adjust_ready) begin
                adjust_valid <= 1'b0;
            end

            // a pulse due while one waits merges into it
            if (fire && !cur.zero && (!adjust_valid || adjust_ready)) begin
                adjust_sign  <= cur.sign;
                adjust_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/divider_multicycle.sv */
// divider_multicycle: restoring unsigned divider, one quotient bit per clock
`timescale 1ns/1ps
`default_nettype none

module divider_multicycle
    import synctimer_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire quotient_t  s_dividend,
    input  wire error_mag_t s_divisor,
    input  wire logic       s_valid,
    output logic            s_ready,
    output quotient_t       m_quotient,
    output logic            m_valid
);

    localparam int REM_WIDTH = TIMER_WIDTH + ERROR_Q + 1;      // divisor plus one
    localparam int CNT_WIDTH = $clog2(QUOTIENT_WIDTH + 1);

    logic                 busy;
    logic [CNT_WIDTH-1:0] bit_cnt;      // quotient bits still to go
    quotient_t            quot;         // dividend shifts out, quotient shifts in
    error_mag_t           divisor;
    logic [REM_WIDTH-1:0] rem;          // partial remainder
    logic [REM_WIDTH-1:0] rem_shift;
    logic [REM_WIDTH-1:0] rem_diff;
    logic                 start;

    assign start   = s_valid & ~busy;   // start while busy is dropped
    assign s_ready = ~busy;

    // bring down next dividend bit and try subtract
    assign rem_shift = {rem[REM_WIDTH-2:0], quot[QUOTIENT_WIDTH-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor};

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            m_valid <= 1'b0;
        end else begin
            m_valid <= 1'b0;                        // single clock
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_WIDTH'(QUOTIENT_WIDTH);
            end else if (busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == CNT_WIDTH'(1)) begin  // last bit this clock
                    busy    <= 1'b0;
                    m_valid <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            quot    <= s_dividend;
            divisor <= s_divisor;
            rem     <= '0;
        end else if (busy) begin
            if (!rem_diff[REM_WIDTH-1]) begin       // no borrow
                rem  <= rem_diff;
                quot <= {quot[QUOTIENT_WIDTH-2:0], 1'b1};
            end else begin
                rem  <= rem_shift;                  // restore
                quot <= {quot[QUOTIENT_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign m_quotient = quot;   // valid with m_valid

endmodule

`default_nettype wire

/* verilog/phase_error_estimator.sv */
// phase_error_estimator: scaled phase error, low-pass filter, override restart
`timescale 1ns/1ps
`default_nettype none

module phase_error_estimator
    import synctimer_pkg::*;
#(
    parameter int LPF_GAIN_PHASE = 2    // update gain 1/2^N
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   correct_valid,
    input  wire logic   correct_override,
    input  wire time_t  current_time,
    input  wire time_t  correct_time,
    output phase_est_t  phase_est,
    output logic        phase_valid
);

    time_t time_diff;
    assign time_diff = correct_time - current_time;     // wraps like the timers

    // ----------------------------------------
    // stage 1  observation
    // ----------------------------------------
    error_fix_t st1_obs;
    logic       st1_restart;    // override seen
    logic       st1_valid;

    // ----------------------------------------
    // stage 2  gained prediction
    // ----------------------------------------
    error_fix_t st2_obs;
    error_fix_t st2_pred_gain;  // est - est/2^G
    logic       st2_restart;
    logic       st2_valid;

    // ----------------------------------------
    // stage 3  estimate update
    // ----------------------------------------
    error_fix_t est;            // filtered phase error
    logic       est_exists;     // first estimate done
    error_fix_t est_next;

    always_comb begin
        if (st2_restart || !est_exists) begin
            est_next = st2_obs;                                 // take observation as is
        end else begin
            est_next = st2_pred_gain + (st2_obs >>> LPF_GAIN_PHASE);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid   <= 1'b0;
            st2_valid   <= 1'b0;
            phase_valid <= 1'b0;
            est_exists  <= 1'b0;
        end else begin
            st1_valid   <= correct_valid;
            st2_valid   <= st1_valid;
            phase_valid <= st2_valid;
            if (st2_valid) begin
                est_exists <= 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (correct_valid) begin
            st1_obs     <= correct_override ? '0 : error_fix_t'($signed(time_diff)) <<< ERROR_Q;
            st1_restart <= correct_override;
        end

        st2_obs       <= st1_obs;
        st2_restart   <= st1_restart;
        st2_pred_gain <= est - (est >>> LPF_GAIN_PHASE);

        if (st2_valid) begin
            est            <= est_next;
            phase_est.zero <= (est_next == '0);
            phase_est.sign <= est_next[$bits(error_fix_t)-1];
            phase_est.mag  <= est_next[$bits(error_fix_t)-1] ? error_mag_t'(-est_next)
                                                             : error_mag_t'(est_next);
        end
    end

endmodule

`default_nettype wire

/* verilog/cycle_estimator.sv */
// cycle_estimator: clock count between correction strobes with low-pass filter
`timescale 1ns/1ps
`default_nettype none

module cycle_estimator
    import synctimer_pkg::*;
#(
    parameter int LPF_GAIN_CYCLE = 2    // update gain 1/2^N
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       correct_valid,
    output cycle_fix_t      cycle_est,
    output logic            cycle_ready
);

    // ----------------------------------------
    // clock counter
    // ----------------------------------------
    count_t count;          // clocks since last strobe
    logic   count_enable;   // first strobe seen

    always_ff @(posedge clk) begin
        if (reset) begin
            count        <= '0;
            count_enable <= 1'b0;
        end else begin
            count <= count + count_t'(1);
            if (correct_valid) begin
                count        <= count_t'(1);  // restart
                count_enable <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // observation latch and filter
    // ----------------------------------------
    cycle_fix_t obs;        // scaled count
    logic       obs_valid;  // one clock after strobe

    always_ff @(posedge clk) begin
        if (reset) begin
            obs         <= '0;
            obs_valid   <= 1'b0;
            cycle_est   <= '0;
            cycle_ready <= 1'b0;
        end else begin
            obs_valid <= correct_valid & count_enable;  // first strobe only starts count
            if (correct_valid) begin
                obs <= cycle_fix_t'(count) << ERROR_Q;
            end

            if (obs_valid) begin
                if (cycle_ready) begin
                    // old - old/2^G + obs/2^G
                    cycle_est <= cycle_est - (cycle_est >> LPF_GAIN_CYCLE)
                               + (obs >> LPF_GAIN_CYCLE);
                end else begin
                    cycle_est <= obs;   // first estimate taken as is
                end
                cycle_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/synctimer_pkg.sv */
// widths, fixed-point types and stage handoff structs for the timer sync adjuster
`default_nettype none

package synctimer_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int TIMER_WIDTH = 32;            // local and true time values
    localparam int CYCLE_WIDTH = 20;            // clocks between corrections
    localparam int ERROR_Q     = 8;             // fraction bits of error and cycle
    localparam int ADJUST_Q    = 8;             // fraction bits of pulse interval
    localparam int QUOTIENT_WIDTH = CYCLE_WIDTH + ERROR_Q + ADJUST_Q;

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef logic [TIMER_WIDTH-1:0]            time_t;
    typedef logic [CYCLE_WIDTH-1:0]            count_t;      // raw clock count
    typedef logic [CYCLE_WIDTH+ERROR_Q-1:0]    cycle_fix_t;  // filtered count, Q.ERROR_Q
    typedef logic signed [TIMER_WIDTH+ERROR_Q-1:0] error_fix_t; // phase error, Q.ERROR_Q
    typedef logic [TIMER_WIDTH+ERROR_Q-1:0]    error_mag_t;  // |error|, same scale
    typedef logic [QUOTIENT_WIDTH-1:0]         quotient_t;   // Q.ADJUST_Q clocks

    // phase estimate going to the divider stage
    typedef struct packed {
        logic       zero;   // estimate exactly zero
        logic       sign;   // estimate negative
        error_mag_t mag;
    } phase_est_t;

    // interval handed to the pacer
    typedef struct packed {
        logic      zero;    // no pulses
        logic      sign;    // sign carried by each pulse
        quotient_t period;  // in 2^-ADJUST_Q clocks
    } adjust_param_t;

endpackage

`default_nettype wire
